/* list.f */
hw/core_pkg.sv
hw/pipe_reg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_access.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/mips_core.sv
dv/tb_mem.sv
dv/tb_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= list.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Test FAILED, see $(LOG)"; exit 1; }
	@echo "Test PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_core.sv */
`timescale 1ns/1ps

module tb_core
  import core_pkg::*;
();

  localparam int    CLK_PERIOD      = 8;
  localparam int    RESET_CYCLES    = 10;
  localparam int    CYCLES_PER_STEP = 20;
  localparam int    DRAIN_CYCLES    = 12;
  localparam addr_t START_PC        = 32'h0000_0100;

  typedef struct packed {
    inst_t     inst;
    logic      writes;
    reg_addr_t dest;
    data_t     value;
  } step_t;

  typedef struct packed {
    addr_t     addr;
    byte_sel_t bytes;
    data_t     data;
  } store_t;

  logic      clk;
  logic      rst_n;
  logic      stall;
  logic      rom_en;
  addr_t     rom_addr;
  inst_t     rom_read_data;
  ram_req_t  ram_req;
  data_t     ram_read_data;
  wb_debug_t wb_debug;

  step_t  program_table[$];
  store_t stores[$];
  int     wb_steps[$];
  int     wb_seen;
  int     stores_seen;
  logic   table_ready;

  mips_core #(.RESET_PC(START_PC)) i_dut (
    .clk, .rst_n, .stall,
    .rom_en, .rom_addr, .rom_read_data,
    .ram_req, .ram_read_data,
    .wb_debug
  );

  tb_mem i_mem (
    .clk, .rom_en, .rom_addr, .rom_read_data,
    .ram_req, .ram_read_data
  );

  function automatic inst_t encode_r(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                     logic [4:0] shamt, logic [5:0] funct);
    return {OP_SPECIAL, rs, rt, rd, shamt, funct};
  endfunction

  function automatic inst_t encode_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic inst_t encode_j(addr_t target);
    return {OP_J, target[27:2]};
  endfunction

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic expect_write(inst_t inst, reg_addr_t dest, data_t value);
    program_table.push_back('{inst: inst, writes: 1'b1, dest: dest, value: value});
  endtask

  task automatic expect_no_write(inst_t inst);
    program_table.push_back('{inst: inst, writes: 1'b0, dest: '0, value: '0});
  endtask

  task automatic build_program();
    expect_write(encode_i(OP_ADDIU, 5'd0, 5'd1, 16'h0005), 5'd1, 32'h0000_0005);
    expect_write(encode_i(OP_ADDIU, 5'd0, 5'd2, 16'hfffd), 5'd2, 32'hffff_fffd);
    expect_write(encode_r(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU), 5'd3, 32'h0000_0002);
    expect_write(encode_r(5'd3, 5'd1, 5'd4, 5'd0, FN_SUBU), 5'd4, 32'hffff_fffd);
    expect_write(encode_r(5'd4, 5'd1, 5'd5, 5'd0, FN_SLT), 5'd5, 32'h0000_0001);
    expect_write(encode_r(5'd1, 5'd4, 5'd6, 5'd0, FN_SLT), 5'd6, 32'h0000_0000);
    expect_write(encode_i(OP_LUI, 5'd0, 5'd7, 16'h1234), 5'd7, 32'h1234_0000);
    expect_write(encode_i(OP_ORI, 5'd7, 5'd7, 16'h5678), 5'd7, 32'h1234_5678);
    expect_write(encode_i(OP_ANDI, 5'd7, 5'd8, 16'hff0f), 5'd8, 32'h0000_5608);
    expect_write(encode_r(5'd7, 5'd8, 5'd9, 5'd0, FN_XOR), 5'd9, 32'h1234_0070);
    expect_write(encode_r(5'd9, 5'd5, 5'd10, 5'd0, FN_OR), 5'd10, 32'h1234_0071);
    expect_write(encode_r(5'd10, 5'd7, 5'd11, 5'd0, FN_AND), 5'd11, 32'h1234_0070);
    expect_write(encode_r(5'd0, 5'd7, 5'd12, 5'd4, FN_SLL), 5'd12, 32'h2345_6780);
    expect_write(encode_r(5'd0, 5'd7, 5'd13, 5'd8, FN_SRL), 5'd13, 32'h0012_3456);
    // r0 write is reported but reads back as zero
    expect_write(encode_i(OP_ADDIU, 5'd1, 5'd0, 16'h0007), 5'd0, 32'h0000_000c);
    expect_write(encode_r(5'd0, 5'd1, 5'd14, 5'd0, FN_ADDU), 5'd14, 32'h0000_0005);
    // Stores, then loads with load-use bubbles
    expect_write(encode_i(OP_ADDIU, 5'd0, 5'd15, 16'h0040), 5'd15, 32'h0000_0040);
    expect_no_write(encode_i(OP_SW, 5'd15, 5'd7, 16'h0000));
    expect_no_write(encode_i(OP_SW, 5'd15, 5'd2, 16'h0004));
    expect_write(encode_i(OP_LW, 5'd15, 5'd16, 16'h0000), 5'd16, 32'h1234_5678);
    expect_write(encode_r(5'd16, 5'd1, 5'd17, 5'd0, FN_ADDU), 5'd17, 32'h1234_567d);
    expect_write(encode_i(OP_LB, 5'd15, 5'd18, 16'h0001), 5'd18, 32'h0000_0056);
    expect_write(encode_i(OP_LB, 5'd15, 5'd19, 16'h0004), 5'd19, 32'hffff_fffd);
    expect_write(encode_i(OP_LBU, 5'd15, 5'd20, 16'h0004), 5'd20, 32'h0000_00fd);
    expect_write(encode_r(5'd19, 5'd20, 5'd21, 5'd0, FN_ADDU), 5'd21, 32'h0000_00fa);
    expect_write(encode_i(OP_LBU, 5'd15, 5'd22, 16'h0003), 5'd22, 32'h0000_0012);
    // beq taken, bne not taken, bne taken, beq not taken
    expect_no_write(encode_i(OP_BEQ, 5'd1, 5'd14, 16'd2));
    expect_write(encode_i(OP_ADDIU, 5'd0, 5'd23, 16'h0011), 5'd23, 32'h0000_0011);
    expect_no_write(encode_i(OP_ADDIU, 5'd0, 5'd23, 16'h0022));
    expect_no_write(encode_i(OP_BNE, 5'd1, 5'd14, 16'd2));
    expect_write(encode_i(OP_ADDIU, 5'd0, 5'd24, 16'h0033), 5'd24, 32'h0000_0033);
    expect_write(encode_i(OP_ADDIU, 5'd24, 5'd25, 16'h0001), 5'd25, 32'h0000_0034);
    expect_no_write(encode_i(OP_BNE, 5'd25, 5'd24, 16'd3));
    expect_write(encode_i(OP_ADDIU, 5'd0, 5'd26, 16'h0044), 5'd26, 32'h0000_0044);
    expect_no_write(encode_i(OP_ADDIU, 5'd0, 5'd26, 16'h0055));
    expect_no_write(encode_i(OP_ADDIU, 5'd0, 5'd27, 16'h0066));
    expect_no_write(encode_i(OP_BEQ, 5'd5, 5'd6, 16'd1));
    expect_write(encode_i(OP_LW, 5'd15, 5'd28, 16'h0004), 5'd28, 32'hffff_fffd);
    // Branch waits on the load
    expect_no_write(encode_i(OP_BEQ, 5'd28, 5'd2, 16'd2));
    expect_write(encode_i(OP_ADDIU, 5'd0, 5'd29, 16'h0077), 5'd29, 32'h0000_0077);
    expect_no_write(encode_i(OP_ADDIU, 5'd0, 5'd29, 16'h0088));
    expect_no_write(encode_j(START_PC + 32'd176));
    expect_write(encode_i(OP_ORI, 5'd0, 5'd30, 16'h0099), 5'd30, 32'h0000_0099);
    expect_no_write(encode_i(OP_ORI, 5'd0, 5'd30, 16'h00aa));
    expect_no_write(encode_i(OP_SW, 5'd15, 5'd30, 16'h0008));
    expect_write(encode_i(OP_LW, 5'd15, 5'd31, 16'h0008), 5'd31, 32'h0000_0099);
    expect_write(encode_r(5'd31, 5'd31, 5'd3, 5'd0, FN_ADDU), 5'd3, 32'h0000_0132);
    // Park on a jump to itself with a nop slot
    expect_no_write(encode_j(START_PC + 32'd188));
    expect_no_write(32'h0000_0000);

    stores.push_back('{addr: 32'h0000_0040, bytes: 4'b1111, data: 32'h1234_5678});
    stores.push_back('{addr: 32'h0000_0044, bytes: 4'b1111, data: 32'hffff_fffd});
    stores.push_back('{addr: 32'h0000_0048, bytes: 4'b1111, data: 32'h0000_0099});
  endtask

  // Fetch runs from the start address, nothing retires or touches the RAM
  task automatic check_reset_state();
    assert (rom_en === 1'b1) else
      abort_run($sformatf("ERROR: rom_en got 0x%01h expected 0x1", rom_en));
    assert (rom_addr === START_PC) else
      abort_run($sformatf("ERROR: rom_addr got 0x%08h expected 0x%08h",
                          rom_addr, START_PC));
    assert (ram_req.en === 1'b0) else
      abort_run($sformatf("ERROR: ram_req.en got 0x%01h expected 0x0", ram_req.en));
    assert (wb_debug.write_en === 1'b0) else
      abort_run($sformatf("ERROR: wb_debug.write_en got 0x%01h expected 0x0",
                          wb_debug.write_en));
  endtask

  task automatic check_writeback();
    int    idx;
    addr_t exp_pc;
    assert (wb_seen < wb_steps.size()) else
      abort_run($sformatf("Register write at pc 0x%08h after the last expected one",
                          wb_debug.pc));
    idx    = wb_steps[wb_seen];
    exp_pc = START_PC + 4 * idx;
    assert (wb_debug.pc == exp_pc) else
      abort_run($sformatf("ERROR: wb_debug.pc got 0x%08h expected 0x%08h",
                          wb_debug.pc, exp_pc));
    assert (wb_debug.write_addr == program_table[idx].dest) else
      abort_run($sformatf("ERROR: wb_debug.write_addr got 0x%02h expected 0x%02h",
                          wb_debug.write_addr, program_table[idx].dest));
    assert (wb_debug.write_data == program_table[idx].value) else
      abort_run($sformatf("ERROR: wb_debug.write_data got 0x%08h expected 0x%08h",
                          wb_debug.write_data, program_table[idx].value));
    wb_seen++;
  endtask

  task automatic check_ram();
    store_t exp;
    assert (!(stall && ram_req.en)) else
      abort_run("The RAM was accessed in a cycle with the external stall high");
    if (ram_req.en && ram_req.write_en != '0) begin
      assert (stores_seen < stores.size()) else
        abort_run($sformatf("Store to 0x%08h after the last expected one", ram_req.addr));
      exp = stores[stores_seen];
      assert (ram_req.addr == exp.addr) else
        abort_run($sformatf("ERROR: ram_req.addr got 0x%08h expected 0x%08h",
                            ram_req.addr, exp.addr));
      assert (ram_req.write_en == exp.bytes) else
        abort_run($sformatf("ERROR: ram_req.write_en got 0x%01h expected 0x%01h",
                            ram_req.write_en, exp.bytes));
      assert (ram_req.write_data == exp.data) else
        abort_run($sformatf("ERROR: ram_req.write_data got 0x%08h expected 0x%08h",
                            ram_req.write_data, exp.data));
      stores_seen++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Outputs are settled by the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (wb_debug.write_en) begin
        check_writeback();
      end
      check_ram();
    end
  end

  // Random stall, about one cycle in four
  initial begin
    logic [15:0] lfsr;
    logic        bit_a;
    logic        bit_b;
    lfsr = 16'd20;
    @(posedge rst_n);
    forever begin
      @(posedge clk);
      lfsr  = lfsr_next(lfsr);
      bit_a = lfsr[0];
      lfsr  = lfsr_next(lfsr);
      bit_b = lfsr[0];
      stall <= bit_a & bit_b;
    end
  end

  initial begin
    wait (table_ready);
    #((RESET_CYCLES + CYCLES_PER_STEP * program_table.size()) * CLK_PERIOD);
    abort_run("Timeout: the program did not retire within the time limit");
  end

  initial begin
    rst_n       = 1'b0;
    stall       = 1'b0;
    wb_seen     = 0;
    stores_seen = 0;
    table_ready = 1'b0;
    build_program();
    i_mem.clear_rom();
    foreach (program_table[i]) begin
      i_mem.load_rom(START_PC + 4 * i, program_table[i].inst);
      if (program_table[i].writes) begin
        wb_steps.push_back(i);
      end
    end
    table_ready = 1'b1;

    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_reset_state();
    @(posedge clk);
    rst_n <= 1'b1;

    wait (wb_seen == wb_steps.size() && stores_seen == stores.size());
    // Skipped instructions would show up here
    repeat (DRAIN_CYCLES) @(posedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* dv/tb_mem.sv */
`timescale 1ns/1ps

module tb_mem import core_pkg::*; (
  input  logic     clk,
  input  logic     rom_en,
  input  addr_t    rom_addr,
  output inst_t    rom_read_data,
  input  ram_req_t ram_req,
  output data_t    ram_read_data
);

  // 1 KiB each, upper address bits ignored
  inst_t rom [256];
  data_t ram [256];

  initial begin
    ram = '{default: '0};
  end

  assign rom_read_data = rom_en ? rom[rom_addr[9:2]] : '0;
  assign ram_read_data = ram[ram_req.addr[9:2]];

  always @(posedge clk) begin
    if (ram_req.en) begin
      for (int b = 0; b < 4; b++) begin
        if (ram_req.write_en[b]) begin
          ram[ram_req.addr[9:2]][8*b +: 8] <= ram_req.write_data[8*b +: 8];
        end
      end
    end
  end

  // Zero words decode as nop
  task automatic clear_rom();
    rom = '{default: '0};
  endtask

  task automatic load_rom(addr_t addr, inst_t inst);
    rom[addr[9:2]] = inst;
  endtask

endmodule

/* hw/mips_core.sv */
`timescale 1ns/1ps

module mips_core import core_pkg::*; #(
  parameter addr_t RESET_PC = '0
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      stall,
  output logic      rom_en,
  output addr_t     rom_addr,
  input  inst_t     rom_read_data,
  output ram_req_t  ram_req,
  input  data_t     ram_read_data,
  output wb_debug_t wb_debug
);

  logic      hold_front;
  logic      bubble_ex;
  logic      hold_back;
  logic      branch_taken;
  addr_t     branch_target;
  addr_t     id_pc;
  inst_t     id_inst;
  reg_addr_t rs_addr;
  reg_addr_t rt_addr;
  logic      rs_read;
  logic      rt_read;
  data_t     rf_rs_data;
  data_t     rf_rt_data;
  data_t     rs_data;
  data_t     rt_data;
  id_ex_t    id_ex_d;
  id_ex_t    id_ex_q;
  ex_mem_t   ex_mem_d;
  ex_mem_t   ex_mem_q;
  mem_wb_t   mem_wb_d;
  mem_wb_t   mem_wb_q;
  wb_t       wb;

  fetch_stage #(.RESET_PC(RESET_PC)) i_fetch (
    .clk, .rst_n,
    .hold          (hold_front),
    .branch_taken, .branch_target,
    .rom_en, .rom_addr, .rom_read_data,
    .id_pc, .id_inst
  );

  decode_stage i_decode (
    .id_pc, .id_inst,
    .rs_addr, .rt_addr, .rs_read, .rt_read,
    .rs_data, .rt_data,
    .branch_taken, .branch_target,
    .id_ex         (id_ex_d)
  );

  hazard_unit i_hazard (
    .clk, .rst_n,
    .rs_addr, .rt_addr, .rs_read, .rt_read,
    .rf_rs_data, .rf_rt_data,
    .ex_out        (ex_mem_d),
    .mem_out       (mem_wb_d),
    .id_ex_q, .stall,
    .rs_data, .rt_data,
    .hold_front, .bubble_ex, .hold_back
  );

  reg_file i_reg_file (
    .clk, .rst_n,
    .rs_addr, .rt_addr,
    .rs_data       (rf_rs_data),
    .rt_data       (rf_rt_data),
    .wb
  );

  pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
    .clk, .rst_n,
    .hold          (hold_back),
    .bubble        (bubble_ex),
    .d             (id_ex_d),
    .q             (id_ex_q)
  );

  execute_stage i_execute (
    .id_ex_q,
    .ex_out        (ex_mem_d)
  );

  pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
    .clk, .rst_n,
    .hold          (hold_back),
    .bubble        (1'b0),
    .d             (ex_mem_d),
    .q             (ex_mem_q)
  );

  mem_access i_mem_access (
    .stall, .ex_mem_q, .ram_req,
    .mem_wb_d, .mem_wb_q, .ram_read_data,
    .wb, .wb_debug
  );

  pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
    .clk, .rst_n,
    .hold          (hold_back),
    .bubble        (1'b0),
    .d             (mem_wb_d),
    .q             (mem_wb_q)
  );

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs_addr,
  input  reg_addr_t rt_addr,
  input  logic      rs_read,
  input  logic      rt_read,
  input  data_t     rf_rs_data,
  input  data_t     rf_rt_data,
  input  ex_mem_t   ex_out,
  input  mem_wb_t   mem_out,
  input  id_ex_t    id_ex_q,
  input  logic      stall,
  output data_t     rs_data,
  output data_t     rt_data,
  output logic      hold_front,
  output logic      bubble_ex,
  output logic      hold_back
);

  logic load_use;

  // Youngest producer wins; a load in execute has no data yet
  function automatic data_t bypass(reg_addr_t addr, data_t rf_data);
    if (addr == '0) begin
      return '0;
    end
    if (ex_out.reg_write_en && ex_out.reg_write_addr == addr && !is_load(ex_out.mem_op)) begin
      return ex_out.result;
    end
    if (mem_out.reg_write_en && mem_out.reg_write_addr == addr) begin
      return load_data(mem_out.mem_op, mem_out.byte_offset, mem_out.result);
    end
    return rf_data;
  endfunction

  assign rs_data = bypass(rs_addr, rf_rs_data);
  assign rt_data = bypass(rt_addr, rf_rt_data);

  assign load_use = is_load(id_ex_q.mem_op) && id_ex_q.reg_write_en &&
                    (id_ex_q.reg_write_addr != '0) &&
                    ((rs_read && id_ex_q.reg_write_addr == rs_addr) ||
                     (rt_read && id_ex_q.reg_write_addr == rt_addr));

  assign hold_front = load_use || stall;
  assign bubble_ex  = load_use && !stall;
  assign hold_back  = stall;

  // One bubble clears the dependency
  single_bubble: assert property (
    @(posedge clk) disable iff (!rst_n) (load_use && !stall) |=> !load_use
  );

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs_addr,
  input  reg_addr_t rt_addr,
  output data_t     rs_data,
  output data_t     rt_data,
  input  wb_t       wb
);

  data_t regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.write_en && wb.write_addr != '0) begin
      regs[wb.write_addr] <= wb.write_data;
    end
  end

  // Writeback in the same cycle shows up on the read port
  assign rs_data = (rs_addr == '0) ? '0 :
                   (wb.write_en && wb.write_addr == rs_addr) ? wb.write_data : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 :
                   (wb.write_en && wb.write_addr == rt_addr) ? wb.write_data : regs[rt_addr];

endmodule

/* hw/mem_access.sv */
`timescale 1ns/1ps

module mem_access import core_pkg::*; (
  input  logic      stall,
  input  ex_mem_t   ex_mem_q,
  output ram_req_t  ram_req,
  output mem_wb_t   mem_wb_d,
  input  mem_wb_t   mem_wb_q,
  input  data_t     ram_read_data,
  output wb_t       wb,
  output wb_debug_t wb_debug
);

  logic is_store;
  logic wb_fire;

  assign is_store = (ex_mem_q.mem_op == MEM_SW);

  // No RAM access at all while frozen
  always_comb begin
    ram_req.en         = (ex_mem_q.mem_op != MEM_NONE) && !stall;
    ram_req.write_en   = (is_store && !stall) ? 4'b1111 : 4'b0000;
    ram_req.addr       = {ex_mem_q.result[31:2], 2'b00};
    ram_req.write_data = ex_mem_q.store_data;

    if (ex_mem_q.mem_op inside {MEM_LW, MEM_SW}) begin
      word_aligned: assert (ex_mem_q.result[1:0] == 2'b00);
    end
  end

  always_comb begin
    mem_wb_d.mem_op         = ex_mem_q.mem_op;
    mem_wb_d.byte_offset    = ex_mem_q.result[1:0];
    mem_wb_d.result         = is_load(ex_mem_q.mem_op) ? ram_read_data : ex_mem_q.result;
    mem_wb_d.reg_write_en   = ex_mem_q.reg_write_en;
    mem_wb_d.reg_write_addr = ex_mem_q.reg_write_addr;
    mem_wb_d.pc             = ex_mem_q.pc;
  end

  // One pulse per instruction, the held MEM/WB entry retires when stall drops
  assign wb_fire = mem_wb_q.reg_write_en && !stall;

  always_comb begin
    wb.write_en   = wb_fire && (mem_wb_q.reg_write_addr != '0);
    wb.write_addr = mem_wb_q.reg_write_addr;
    wb.write_data = load_data(mem_wb_q.mem_op, mem_wb_q.byte_offset, mem_wb_q.result);

    wb_debug.write_en   = wb_fire;
    wb_debug.write_addr = mem_wb_q.reg_write_addr;
    wb_debug.write_data = wb.write_data;
    wb_debug.pc         = mem_wb_q.pc;
  end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
  input  id_ex_t  id_ex_q,
  output ex_mem_t ex_out
);

  data_t op_a;
  data_t op_b;
  data_t result;

  assign op_a = id_ex_q.operand_1;
  assign op_b = id_ex_q.operand_2;

  // Loads and stores use ALU_ADD for the address
  always_comb begin
    case (id_ex_q.alu_op)
      ALU_ADD: result = op_a + op_b;
      ALU_SUB: result = op_a - op_b;
      ALU_AND: result = op_a & op_b;
      ALU_OR:  result = op_a | op_b;
      ALU_XOR: result = op_a ^ op_b;
      ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLL: result = op_b << id_ex_q.shamt;
      ALU_SRL: result = op_b >> id_ex_q.shamt;
      ALU_LUI: result = {op_b[15:0], 16'b0};
      default: result = op_a + op_b;
    endcase
  end

  always_comb begin
    ex_out.mem_op         = id_ex_q.mem_op;
    ex_out.store_data     = id_ex_q.store_data;
    ex_out.result         = result;
    ex_out.reg_write_en   = id_ex_q.reg_write_en;
    ex_out.reg_write_addr = id_ex_q.reg_write_addr;
    ex_out.pc             = id_ex_q.pc;
  end

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
  input  addr_t     id_pc,
  input  inst_t     id_inst,
  output reg_addr_t rs_addr,
  output reg_addr_t rt_addr,
  output logic      rs_read,
  output logic      rt_read,
  input  data_t     rs_data,
  input  data_t     rt_data,
  output logic      branch_taken,
  output addr_t     branch_target,
  output id_ex_t    id_ex
);

  logic [5:0] opcode;
  logic [5:0] funct;
  reg_addr_t  rd_addr;
  data_t      imm_sext;
  data_t      imm_zext;
  addr_t      pc_plus4;
  logic       legal;

  assign opcode   = id_inst[31:26];
  assign funct    = id_inst[5:0];
  assign rs_addr  = id_inst[25:21];
  assign rt_addr  = id_inst[20:16];
  assign rd_addr  = id_inst[15:11];
  assign imm_sext = {{16{id_inst[15]}}, id_inst[15:0]};
  assign imm_zext = {16'b0, id_inst[15:0]};
  assign pc_plus4 = id_pc + 32'd4;

  always_comb begin
    // Implemented opcodes and function codes
    legal                = (opcode == OP_SPECIAL) ?
                           (funct inside {FN_SLL, FN_SRL, FN_ADDU, FN_SUBU,
                                          FN_AND, FN_OR, FN_XOR, FN_SLT}) :
                           (opcode inside {OP_J, OP_BEQ, OP_BNE, OP_ADDIU, OP_ANDI, OP_ORI,
                                           OP_LUI, OP_LB, OP_LW, OP_LBU, OP_SW});
    rs_read              = 1'b0;
    rt_read              = 1'b0;
    branch_taken         = 1'b0;
    branch_target        = pc_plus4 + {imm_sext[29:0], 2'b00};
    id_ex.alu_op         = ALU_ADD;
    id_ex.shamt          = id_inst[10:6];
    id_ex.operand_1      = rs_data;
    id_ex.operand_2      = rt_data;
    id_ex.mem_op         = MEM_NONE;
    id_ex.store_data     = rt_data;
    id_ex.reg_write_en   = 1'b0;
    id_ex.reg_write_addr = rt_addr;
    id_ex.pc             = id_pc;

    case (opcode)
      OP_SPECIAL: begin
        rs_read              = 1'b1;
        rt_read              = 1'b1;
        id_ex.reg_write_en   = 1'b1;
        id_ex.reg_write_addr = rd_addr;
        case (funct)
          FN_ADDU: id_ex.alu_op = ALU_ADD;
          FN_SUBU: id_ex.alu_op = ALU_SUB;
          FN_AND:  id_ex.alu_op = ALU_AND;
          FN_OR:   id_ex.alu_op = ALU_OR;
          FN_XOR:  id_ex.alu_op = ALU_XOR;
          FN_SLT:  id_ex.alu_op = ALU_SLT;
          FN_SLL, FN_SRL: begin
            id_ex.alu_op = (funct == FN_SLL) ? ALU_SLL : ALU_SRL;
            rs_read      = 1'b0;
          end
          default: id_ex.reg_write_en = 1'b0;
        endcase
      end
      OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
        rs_read            = (opcode != OP_LUI);
        id_ex.reg_write_en = 1'b1;
        id_ex.operand_2    = (opcode == OP_ADDIU) ? imm_sext : imm_zext;
        id_ex.alu_op       = (opcode == OP_ANDI) ? ALU_AND :
                             (opcode == OP_ORI)  ? ALU_OR  :
                             (opcode == OP_LUI)  ? ALU_LUI : ALU_ADD;
      end
      OP_LW, OP_LB, OP_LBU: begin
        rs_read            = 1'b1;
        id_ex.reg_write_en = 1'b1;
        id_ex.operand_2    = imm_sext;
        id_ex.mem_op       = (opcode == OP_LW) ? MEM_LW :
                             (opcode == OP_LB) ? MEM_LB : MEM_LBU;
      end
      OP_SW: begin
        rs_read         = 1'b1;
        rt_read         = 1'b1;
        id_ex.operand_2 = imm_sext;
        id_ex.mem_op    = MEM_SW;
      end
      OP_BEQ, OP_BNE: begin
        rs_read      = 1'b1;
        rt_read      = 1'b1;
        branch_taken = (rs_data == rt_data) ^ (opcode == OP_BNE);
      end
      OP_J: begin
        branch_taken  = 1'b1;
        branch_target = {pc_plus4[31:28], id_inst[25:0], 2'b00};
      end
      default: id_ex.reg_write_en = 1'b0;
    endcase

    // Canonical nop, also what IF/ID holds after reset
    if (id_inst == '0) begin
      id_ex.reg_write_en = 1'b0;
    end

    unknown_no_write: assert (legal || !id_ex.reg_write_en);
  end

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; #(
  parameter addr_t RESET_PC = '0
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  hold,
  input  logic  branch_taken,
  input  addr_t branch_target,
  output logic  rom_en,
  output addr_t rom_addr,
  input  inst_t rom_read_data,
  output addr_t id_pc,
  output inst_t id_inst
);

  addr_t pc;

  // ROM is read every cycle, a held IF/ID simply ignores the data
  assign rom_en   = 1'b1;
  assign rom_addr = pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= RESET_PC;
      id_pc   <= RESET_PC;
      id_inst <= '0;
    end else if (!hold) begin
      // Branch in decode redirects after its delay slot is fetched
      pc      <= branch_taken ? branch_target : pc + 32'd4;
      id_pc   <= pc;
      id_inst <= rom_read_data;
    end
  end

endmodule

/* hw/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     hold,
  input  logic     bubble,
  input  payload_t d,
  output payload_t q
);

  // A zero payload carries no register write and no memory access
  always_ff @(posedge clk) begin
    if (!rst_n || bubble) begin
      q <= '0;
    end else if (!hold) begin
      q <= d;
    end
  end

  // Hazard control never asks a stage to hold and flush at once
  hold_bubble_excl: assert property (
    @(posedge clk) disable iff (!rst_n) !(hold && bubble)
  );

endmodule

/* hw/core_pkg.sv */
package core_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  byte_sel_t;

  // Primary opcodes
  localparam logic [5:0] OP_SPECIAL = 6'h00;
  localparam logic [5:0] OP_J       = 6'h02;
  localparam logic [5:0] OP_BEQ     = 6'h04;
  localparam logic [5:0] OP_BNE     = 6'h05;
  localparam logic [5:0] OP_ADDIU   = 6'h09;
  localparam logic [5:0] OP_ANDI    = 6'h0c;
  localparam logic [5:0] OP_ORI     = 6'h0d;
  localparam logic [5:0] OP_LUI     = 6'h0f;
  localparam logic [5:0] OP_LB      = 6'h20;
  localparam logic [5:0] OP_LW      = 6'h23;
  localparam logic [5:0] OP_LBU     = 6'h24;
  localparam logic [5:0] OP_SW      = 6'h2b;

  // SPECIAL function codes
  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_SRL  = 6'h02;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_SLT  = 6'h2a;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW
  } mem_op_e;

  typedef struct packed {
    alu_op_e   alu_op;
    logic [4:0] shamt;
    data_t     operand_1;
    data_t     operand_2;
    mem_op_e   mem_op;
    data_t     store_data;
    logic      reg_write_en;
    reg_addr_t reg_write_addr;
    addr_t     pc;
  } id_ex_t;

  typedef struct packed {
    mem_op_e   mem_op;
    data_t     store_data;
    data_t     result;
    logic      reg_write_en;
    reg_addr_t reg_write_addr;
    addr_t     pc;
  } ex_mem_t;

  // For loads, result holds the raw RAM word until writeback
  typedef struct packed {
    mem_op_e    mem_op;
    logic [1:0] byte_offset;
    data_t      result;
    logic       reg_write_en;
    reg_addr_t  reg_write_addr;
    addr_t      pc;
  } mem_wb_t;

  typedef struct packed {
    logic      en;
    byte_sel_t write_en;
    addr_t     addr;
    data_t     write_data;
  } ram_req_t;

  typedef struct packed {
    logic      write_en;
    reg_addr_t write_addr;
    data_t     write_data;
    addr_t     pc;
  } wb_debug_t;

  typedef struct packed {
    logic      write_en;
    reg_addr_t write_addr;
    data_t     write_data;
  } wb_t;

  function automatic logic is_load(mem_op_e op);
    return op inside {MEM_LW, MEM_LB, MEM_LBU};
  endfunction

  // Byte lanes are little endian
  function automatic data_t load_data(mem_op_e op, logic [1:0] offset, data_t word);
    logic [7:0] lane;
    lane = word[{offset, 3'b000} +: 8];
    case (op)
      MEM_LB:  return {{24{lane[7]}}, lane};
      MEM_LBU: return {24'b0, lane};
      default: return word;
    endcase
  endfunction

endpackage
